// ==== source/tetrisPkg.sv ====
`default_nettype none

package tetrisPkg;

    localparam int ROWS      = 20;
    localparam int COLS      = 10;
    localparam int SPAWN_COL = 3;    // Left edge of the 4x4 piece box

    typedef logic [4:0]        rowIdxT;
    typedef logic signed [4:0] colIdxT;    // Signed so a move past column 0 shows up

    typedef logic [ROWS-1:0][COLS-1:0] boardT;    // [row][col], row 0 on top

    typedef enum logic [2:0] {
        LINE    = 3'd0,
        SQUARE  = 3'd1,
        LSHAPE  = 3'd2,
        RLSHAPE = 3'd3,
        SSHAPE  = 3'd4,
        ZSHAPE  = 3'd5,
        TSHAPE  = 3'd6
    } pieceKindT;

    typedef enum logic [2:0] {
        IDLE,
        SPAWN,
        FALL,
        WAIT,
        OVER
    } dropStateT;

    typedef struct packed {
        pieceKindT kind;
        rowIdxT    row;
        colIdxT    col;
    } landEventT;

    // Cells of the piece inside its 4x4 box, bit index is boxRow*4 + boxCol.
    // Cells that fall outside the board are left out of the mask.
    function automatic boardT pieceMask(input pieceKindT kind, input rowIdxT row,
                                        input colIdxT col);
        boardT       mask;
        logic [15:0] shape;
        int          r;
        int          c;
        mask = '0;
        case (kind)
            LINE:    shape = 16'h2222;
            SQUARE:  shape = 16'h0066;
            LSHAPE:  shape = 16'h0622;
            RLSHAPE: shape = 16'h0644;
            SSHAPE:  shape = 16'h006C;
            ZSHAPE:  shape = 16'h00C6;
            TSHAPE:  shape = 16'h0072;
            default: shape = 16'h0000;
        endcase
        for (int dr = 0; dr < 4; dr++) begin
            for (int dc = 0; dc < 4; dc++) begin
                r = int'(row) + dr;
                c = int'(col) + dc;    // Sign extended column
                if (shape[dr*4+dc] && r < ROWS && c >= 0 && c < COLS) begin
                    mask[r][c] = 1'b1;
                end
            end
        end
        return mask;
    endfunction

endpackage

`default_nettype wire

// ==== source/pieceSelect.sv ====
`timescale 1ns/1ps
`default_nettype none

module pieceSelect #(
    parameter logic [7:0] LFSR_SEED = 8'hA5
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 pieceReq,
    input  logic                 fixedEn,
    input  tetrisPkg::pieceKindT fixedKind,
    output logic                 kindValid,
    output tetrisPkg::pieceKindT nextKind
);
    import tetrisPkg::*;

    logic [7:0] lfsr;
    logic [7:0] lfsrNext;
    logic [7:0] lfsrMod;
    logic       feedback;

    assign feedback = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];    // Fibonacci taps
    assign lfsrNext = {lfsr[6:0], feedback};
    assign lfsrMod  = lfsrNext % 8'd7;    // Always below 7, fits a kind

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr      <= LFSR_SEED;
            kindValid <= 1'b0;
        end else begin
            kindValid <= pieceReq;    // Answer one cycle after the request
            if (pieceReq && !fixedEn) begin
                lfsr <= lfsrNext;    // Fixed mode keeps the sequence where it is
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pieceReq) begin
            if (fixedEn) begin
                nextKind <= fixedKind;
            end else begin
                nextKind <= pieceKindT'(lfsrMod[2:0]);
            end
        end
    end

    // One answer per request, and requests are single-cycle pulses
    kindValidPulse: assert property (@(posedge clk) disable iff (rst)
        kindValid |=> !kindValid);

endmodule

`default_nettype wire

// ==== source/pieceDrop.sv ====
`timescale 1ns/1ps
`default_nettype none

module pieceDrop (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic                 tick,
    input  logic                 moveLeft,
    input  logic                 moveRight,
    input  logic                 kindValid,
    input  tetrisPkg::pieceKindT nextKind,
    input  tetrisPkg::boardT     board,
    input  logic                 busy,
    output logic                 pieceReq,
    output logic                 landed,
    output tetrisPkg::landEventT landInfo,
    output tetrisPkg::boardT     screen,
    output logic                 gameOver
);
    import tetrisPkg::*;

    dropStateT state;
    pieceKindT curKind;
    rowIdxT    curRow;
    colIdxT    curCol;

    boardT  curMask;
    boardT  spawnMask;
    boardT  moveMask;
    boardT  downMask;
    colIdxT tryCol;     // Column asked for by the move strobes
    colIdxT moveCol;    // Column after this cycle's move
    logic   spawnFree;
    logic   downFree;

    // A piece fits when all four cells are on the board and none is taken
    function automatic logic fits(input boardT mask, input boardT stack);
        return ($countones(mask) == 4) && ((mask & stack) == '0);
    endfunction

    always_comb begin
        tryCol = curCol;
        if (moveLeft && !moveRight) begin
            tryCol = curCol - 5'sd1;
        end else if (moveRight && !moveLeft) begin
            tryCol = curCol + 5'sd1;
        end
    end

    assign curMask   = pieceMask(curKind, curRow, curCol);
    assign moveMask  = pieceMask(curKind, curRow, tryCol);
    assign moveCol   = fits(moveMask, board) ? tryCol : curCol;    // Walls block the move
    assign downMask  = pieceMask(curKind, curRow + 5'd1, moveCol);    // Move first, then drop
    assign downFree  = fits(downMask, board);
    assign spawnMask = pieceMask(nextKind, '0, colIdxT'(SPAWN_COL));
    assign spawnFree = fits(spawnMask, board);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            pieceReq <= 1'b0;
            landed   <= 1'b0;
        end else begin
            pieceReq <= 1'b0;
            landed   <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        state    <= SPAWN;
                        pieceReq <= 1'b1;
                    end
                end
                SPAWN: begin
                    if (kindValid) begin
                        state <= spawnFree ? FALL : OVER;
                    end
                end
                FALL: begin
                    if (tick && !downFree) begin
                        state  <= WAIT;
                        landed <= 1'b1;
                    end
                end
                WAIT: begin
                    // landed is still high while the board has not yet raised busy
                    if (!busy && !landed) begin
                        state    <= SPAWN;
                        pieceReq <= 1'b1;
                    end
                end
                OVER: begin
                    state <= OVER;    // Held until reset
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == SPAWN && kindValid) begin
            curKind <= nextKind;
            curRow  <= '0;
            curCol  <= colIdxT'(SPAWN_COL);
        end else if (state == FALL) begin
            curCol <= moveCol;
            if (tick && downFree) begin
                curRow <= curRow + 5'd1;
            end
            if (tick && !downFree) begin
                landInfo <= '{curKind, curRow, moveCol};    // Sent with the pulse
            end
        end
    end

    assign screen   = (state == FALL) ? (board | curMask) : board;
    assign gameOver = (state == OVER);

    // The stack only changes while no piece is falling
    fallNoOverlap: assert property (@(posedge clk) disable iff (rst)
        (state == FALL) |-> ((curMask & board) == '0));

endmodule

`default_nettype wire

// ==== source/boardStore.sv ====
`timescale 1ns/1ps
`default_nettype none

module boardStore (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 landed,
    input  tetrisPkg::landEventT landInfo,
    output tetrisPkg::boardT     board,
    output logic                 busy,
    output logic [15:0]          linesCleared
);
    import tetrisPkg::*;

    boardT  landMask;
    boardT  shifted;    // Board with scanRow removed
    rowIdxT scanRow;
    logic   rowFull;

    assign landMask = pieceMask(landInfo.kind, landInfo.row, landInfo.col);
    assign rowFull  = &board[scanRow];

    // Rows above scanRow move down by one, the top row comes in empty
    always_comb begin
        shifted    = board;
        shifted[0] = '0;
        for (int r = 1; r < ROWS; r++) begin
            if (r <= int'(scanRow)) begin
                shifted[r] = board[r-1];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            board        <= '0;
            busy         <= 1'b0;
            scanRow      <= '0;
            linesCleared <= '0;
        end else if (landed) begin
            board   <= board | landMask;    // Merge the landed piece
            busy    <= 1'b1;
            scanRow <= rowIdxT'(ROWS - 1);    // Scan starts at the bottom
        end else if (busy) begin
            if (rowFull) begin
                board        <= shifted;
                linesCleared <= linesCleared + 16'd1;
                // Same row again, a new row has dropped into it
            end else if (scanRow == '0) begin
                busy <= 1'b0;    // Top row done
            end else begin
                scanRow <= scanRow - 5'd1;
            end
        end
    end

    // The drop engine waits in WAIT until the scan is over
    noLandWhileBusy: assert property (@(posedge clk) disable iff (rst)
        landed |-> !busy);

endmodule

`default_nettype wire

// ==== source/tetrisTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module tetrisTop #(
    parameter logic [7:0] LFSR_SEED = 8'hA5
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic                 tick,
    input  logic                 moveLeft,
    input  logic                 moveRight,
    input  logic                 fixedEn,
    input  tetrisPkg::pieceKindT fixedKind,
    output tetrisPkg::boardT     screen,
    output logic                 landed,
    output logic [15:0]          linesCleared,
    output logic                 busy,
    output logic                 gameOver
);
    import tetrisPkg::*;

    logic      pieceReq;
    logic      kindValid;
    pieceKindT nextKind;
    landEventT landInfo;
    boardT     board;    // Stack without the falling piece

    pieceSelect #(
        .LFSR_SEED(LFSR_SEED)
    ) selectInst (
        .clk      (clk),
        .rst      (rst),
        .pieceReq (pieceReq),
        .fixedEn  (fixedEn),
        .fixedKind(fixedKind),
        .kindValid(kindValid),
        .nextKind (nextKind)
    );

    pieceDrop dropInst (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .tick     (tick),
        .moveLeft (moveLeft),
        .moveRight(moveRight),
        .kindValid(kindValid),
        .nextKind (nextKind),
        .board    (board),
        .busy     (busy),
        .pieceReq (pieceReq),
        .landed   (landed),
        .landInfo (landInfo),
        .screen   (screen),
        .gameOver (gameOver)
    );

    boardStore storeInst (
        .clk         (clk),
        .rst         (rst),
        .landed      (landed),
        .landInfo    (landInfo),
        .board       (board),
        .busy        (busy),
        .linesCleared(linesCleared)
    );

endmodule

`default_nettype wire

// ==== tb/tetrisTests.svh ====
`ifndef TETRIS_TESTS_SVH
`define TETRIS_TESTS_SVH

task automatic resetAndSpawn();
    int cycles;
    testName = "resetAndSpawn";
    resetDut();
    boardCompare("empty screen", '0, screen);
    flagCompare("landed", 1'b0, landed);
    flagCompare("busy", 1'b0, busy);
    flagCompare("gameOver", 1'b0, gameOver);
    countCompare("lines", 16'd0, linesCleared);
    fixedEn   = 1'b1;
    fixedKind = LINE;
    pulseStart();
    waitSpawn(LINE, cycles);    // Column 4, rows 0 to 3
    countCompare("start to screen", 16'd3, 16'(cycles));
endtask

task automatic freeFall();
    int    cycles;
    int    fallTicks;
    boardT expected;
    testName  = "freeFall";
    resetDut();
    fixedKind = SQUARE;
    pulseStart();
    waitSpawn(SQUARE, cycles);
    dropPiece(fallTicks);
    countCompare("ticks before landing", 16'd18, 16'(fallTicks));
    settleBoard();
    expected        = '0;
    expected[18][4] = 1'b1;
    expected[18][5] = 1'b1;
    expected[19][4] = 1'b1;
    expected[19][5] = 1'b1;
    boardCompare("square at bottom", expected, screen);
endtask

task automatic movesAndWalls();
    pieceKindT kinds[3];
    int        cycles;
    int        burst;
    int        fallTicks;
    bit        left;
    testName  = "movesAndWalls";
    kinds     = '{TSHAPE, LSHAPE, ZSHAPE};
    resetDut();
    fixedKind = kinds[0];
    pulseStart();
    for (int p = 0; p < 3; p++) begin
        waitSpawn(kinds[p], cycles);
        fixedKind = kinds[(p + 1) % 3];    // Taken at the next request
        for (int b = 0; b < 4; b++) begin
            left  = ($random(seed) % 2) != 0;
            burst = 1 + int'({$random(seed)} % 5);    // Long runs reach the walls
            repeat (burst) moveOnce(left);
        end
        dropPiece(fallTicks);
        settleBoard();
    end
endtask

task automatic lineClear();
    int targets[5];
    int cycles;
    int fallTicks;
    testName  = "lineClear";
    targets   = '{-1, 1, 3, 5, 7};    // Squares cover columns 0 to 9
    resetDut();
    fixedKind = SQUARE;
    pulseStart();
    for (int p = 0; p < 5; p++) begin
        waitSpawn(SQUARE, cycles);
        for (int m = 0; m < 6 && curCol > targets[p]; m++) begin
            moveOnce(1'b1);
        end
        for (int m = 0; m < 6 && curCol < targets[p]; m++) begin
            moveOnce(1'b0);
        end
        dropPiece(fallTicks);
        settleBoard();
    end
    countCompare("two lines", 16'd2, linesCleared);
    boardCompare("empty after clear", '0, screen);
endtask

task automatic randomKinds();
    logic [7:0] lfsr;
    pieceKindT  expected;
    int         cycles;
    int         fallTicks;
    testName = "randomKinds";
    resetDut();
    fixedEn  = 1'b0;
    lfsr     = LFSR_SEED;
    pulseStart();
    for (int p = 0; p < 4; p++) begin
        lfsr     = lfsrStep(lfsr);
        expected = pieceKindT'(3'(lfsr % 8'd7));
        waitSpawn(expected, cycles);
        kindCompare("kind on screen", expected, pieceKindT'(kindOnScreen(screen, modelBoard)));
        dropPiece(fallTicks);
        settleBoard();
    end
    fixedEn = 1'b1;
endtask

task automatic gameOverHold();
    int cycles;
    int fallTicks;
    testName  = "gameOverHold";
    resetDut();
    fixedKind = LINE;
    pulseStart();
    for (int p = 0; p < 5; p++) begin
        waitSpawn(LINE, cycles);
        dropPiece(fallTicks);
        settleBoard();
    end
    waitSpawn(LINE, cycles);    // Column 4 is full now
    repeat (5) begin
        tickOnce();
        flagCompare("gameOver held", 1'b1, gameOver);
        boardCompare("frozen screen", modelBoard, screen);
    end
endtask

`endif

// ==== tb/tetrisTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module tetrisTb;
    import tetrisPkg::*;

    localparam int         CLK_PERIOD   = 8;
    localparam int         PIECE_COUNT  = 30;
    localparam int         PIECE_CYCLES = 40;
    localparam int         WATCHDOG_NS  = PIECE_COUNT * PIECE_CYCLES * CLK_PERIOD + 4000;
    localparam logic [7:0] LFSR_SEED    = 8'hA5;

    logic        clk = 1'b0;
    logic        rst;
    logic        start;
    logic        tick;
    logic        moveLeft;
    logic        moveRight;
    logic        fixedEn;
    pieceKindT   fixedKind;
    boardT       screen;
    logic        landed;
    logic [15:0] linesCleared;
    logic        busy;
    logic        gameOver;

    boardT     modelBoard;    // Landed stack as predicted
    int        modelLines;
    pieceKindT curKind;       // Falling piece in the model
    int        curRow;
    int        curCol;
    int        errorCount = 0;
    int        checkCount = 0;
    int        seed = 68;
    string     testName;

    always #(CLK_PERIOD / 2) clk = ~clk;

    tetrisTop #(
        .LFSR_SEED(LFSR_SEED)
    ) DUT (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .tick        (tick),
        .moveLeft    (moveLeft),
        .moveRight   (moveRight),
        .fixedEn     (fixedEn),
        .fixedKind   (fixedKind),
        .screen      (screen),
        .landed      (landed),
        .linesCleared(linesCleared),
        .busy        (busy),
        .gameOver    (gameOver)
    );

    // Four cells as {row, col} pairs inside the 4x4 box
    function automatic logic [15:0] shapeCells(input pieceKindT kind);
        case (kind)
            LINE:    return {2'd0, 2'd1, 2'd1, 2'd1, 2'd2, 2'd1, 2'd3, 2'd1};
            SQUARE:  return {2'd0, 2'd1, 2'd0, 2'd2, 2'd1, 2'd1, 2'd1, 2'd2};
            LSHAPE:  return {2'd0, 2'd1, 2'd1, 2'd1, 2'd2, 2'd1, 2'd2, 2'd2};
            RLSHAPE: return {2'd0, 2'd2, 2'd1, 2'd2, 2'd2, 2'd2, 2'd2, 2'd1};
            SSHAPE:  return {2'd0, 2'd2, 2'd0, 2'd3, 2'd1, 2'd1, 2'd1, 2'd2};
            ZSHAPE:  return {2'd0, 2'd1, 2'd0, 2'd2, 2'd1, 2'd2, 2'd1, 2'd3};
            TSHAPE:  return {2'd0, 2'd1, 2'd1, 2'd0, 2'd1, 2'd1, 2'd1, 2'd2};
            default: return '0;
        endcase
    endfunction

    function automatic boardT cellMask(input pieceKindT kind, input int row, input int col);
        logic [15:0] cells;
        boardT       mask;
        int          r;
        int          c;
        cells = shapeCells(kind);
        mask  = '0;
        for (int i = 0; i < 4; i++) begin
            r = row + int'(cells[15-4*i -: 2]);
            c = col + int'(cells[13-4*i -: 2]);
            if (r >= 0 && r < ROWS && c >= 0 && c < COLS) begin
                mask[r][c] = 1'b1;    // Off-board cells are dropped
            end
        end
        return mask;
    endfunction

    // A lost cell means the piece left the board
    function automatic bit pieceFits(input pieceKindT kind, input int row, input int col,
                                     input boardT stack);
        boardT mask;
        mask = cellMask(kind, row, col);
        return ($countones(mask) == 4) && ((mask & stack) == '0);
    endfunction

    function automatic logic [7:0] lfsrStep(input logic [7:0] v);
        return {v[6:0], v[7] ^ v[5] ^ v[4] ^ v[3]};
    endfunction

    // Kind whose spawn mask matches what the screen adds to the stack
    function automatic logic [2:0] kindOnScreen(input boardT shown, input boardT stack);
        logic [2:0] code;
        code = 3'd7;
        for (int k = 0; k < 7; k++) begin
            if ((shown & ~stack) == cellMask(pieceKindT'(k), 0, SPAWN_COL)) begin
                code = 3'(k);
            end
        end
        return code;
    endfunction

    task automatic clearFullRows(inout boardT b, output int cleared);
        int r;
        cleared = 0;
        r = ROWS - 1;
        while (r >= 0) begin
            if (b[r] == '1) begin
                for (int k = r; k > 0; k--) begin
                    b[k] = b[k-1];
                end
                b[0] = '0;
                cleared++;    // Same row is looked at again
            end else begin
                r--;
            end
        end
    endtask

    task automatic boardCompare(input string what, input boardT expected, input boardT actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("ERR %s %s: expected %h, actual %h", testName, what, expected, actual);
        end
    endtask

    task automatic kindCompare(input string what, input pieceKindT expected,
                               input pieceKindT actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("ERR %s %s: expected %0d, actual %0d", testName, what, expected, actual);
        end
    endtask

    task automatic countCompare(input string what, input logic [15:0] expected,
                                input logic [15:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("ERR %s %s: expected %0d, actual %0d", testName, what, expected, actual);
        end
    endtask

    task automatic flagCompare(input string what, input logic expected, input logic actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("ERR %s %s: expected %b, actual %b", testName, what, expected, actual);
        end
    endtask

    // Driving tasks start and end on a falling edge
    task automatic resetDut();
        rst       = 1'b1;
        start     = 1'b0;
        tick      = 1'b0;
        moveLeft  = 1'b0;
        moveRight = 1'b0;
        repeat (3) @(negedge clk);
        rst        = 1'b0;
        modelBoard = '0;
        modelLines = 0;
    endtask

    task automatic pulseStart();
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic tickOnce();
        tick = 1'b1;
        @(negedge clk);
        tick = 1'b0;
    endtask

    task automatic moveOnce(input bit left);
        int tryCol;
        tryCol    = left ? curCol - 1 : curCol + 1;
        moveLeft  = left;
        moveRight = !left;
        @(negedge clk);
        moveLeft  = 1'b0;
        moveRight = 1'b0;
        if (pieceFits(curKind, curRow, tryCol, modelBoard)) begin
            curCol = tryCol;    // Blocked moves keep the column
        end
        boardCompare("move", modelBoard | cellMask(curKind, curRow, curCol), screen);
    endtask

    task automatic waitSpawn(input pieceKindT kind, output int cycles);
        cycles = 1;
        while (screen === modelBoard && !gameOver && cycles < 60) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles >= 60) begin
            errorCount++;
            $display("%s: no new piece and no game over within 60 cycles", testName);
        end
        curKind = kind;
        curRow  = 0;
        curCol  = SPAWN_COL;
        if (pieceFits(kind, 0, SPAWN_COL, modelBoard)) begin
            flagCompare("spawn gameOver", 1'b0, gameOver);
            boardCompare("spawn", modelBoard | cellMask(kind, 0, SPAWN_COL), screen);
        end else begin
            flagCompare("blocked spawn gameOver", 1'b1, gameOver);
        end
    endtask

    task automatic dropPiece(output int fallTicks);
        fallTicks = 0;
        while (pieceFits(curKind, curRow + 1, curCol, modelBoard)) begin
            tickOnce();
            curRow++;
            if (landed === 1'b0) begin
                fallTicks++;    // Tick the DUT answered without landing
            end
            flagCompare("landed while falling", 1'b0, landed);
            boardCompare("fall", modelBoard | cellMask(curKind, curRow, curCol), screen);
        end
        tickOnce();
        flagCompare("landing pulse", 1'b1, landed);
        modelBoard |= cellMask(curKind, curRow, curCol);
    endtask

    task automatic settleBoard();
        int cleared;
        int highCycles;
        clearFullRows(modelBoard, cleared);
        modelLines += cleared;
        highCycles = 0;
        @(negedge clk);
        flagCompare("landed one cycle", 1'b0, landed);
        while (busy && highCycles < 100) begin
            highCycles++;
            @(negedge clk);
        end
        countCompare("busy cycles", 16'(ROWS + cleared), 16'(highCycles));
        boardCompare("board after scan", modelBoard, screen);    // Screen is the stack here
        countCompare("lines", 16'(modelLines), linesCleared);
    endtask

    `include "tetrisTests.svh"

    initial begin
        rst       = 1'b1;
        start     = 1'b0;
        tick      = 1'b0;
        moveLeft  = 1'b0;
        moveRight = 1'b0;
        fixedEn   = 1'b1;
        fixedKind = LINE;
        resetAndSpawn();
        freeFall();
        movesAndWalls();
        lineClear();
        randomKinds();
        gameOverHold();
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+tb
source/tetrisPkg.sv
source/pieceSelect.sv
source/pieceDrop.sv
source/boardStore.sv
source/tetrisTop.sv
tb/tetrisTb.sv

// ==== Makefile ====
TOP     = tetrisTb
SIM_LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f build.f

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) \
		-f build.f -o simv
	./obj_dir/simv | tee $(SIM_LOG)
	grep -q "Simulation PASSED" $(SIM_LOG)

clean:
	rm -rf obj_dir $(SIM_LOG)
